// File: verilog.f
design/dqmPkg.sv
design/dqmRegs.sv
design/bitStrobeGen.sv
design/mseAccumulator.sv
design/log10Approx.sv
design/dqmTop.sv
bench/dqmModel.sv
bench/dqmTb.sv

// File: bench/dqmTb.sv
module dqmTb;

    timeunit 1ns;
    timeprecision 100ps;

    import dqmPkg::*;
    import dqmModel::*;

    logic               busClk;
    logic               reset;
    dqmBusReq           busReq;
    sampleBus           samples;
    logic [31:0]        dataOut;
    logic signed [15:0] log10Mse;
    logic               log10Valid;
    dqmConfig           cfgOut;

    modelState   st;
    logic [31:0] rngState;
    int          cycleNo;
    int          errorCount;
    int          testErrors;
    int          testsRun;
    int          testsFailed;
    int          pulseCycles[$];
    // clksPerBit and window length pairs for the spacing test.
    int          cpbList[4] = '{4, 1, 10, 3};
    int          lenList[4] = '{3, 5, 2, 1};

    dqmTop DUT (
        .busClk     (busClk),
        .reset      (reset),
        .busReq     (busReq),
        .samples    (samples),
        .dataOut    (dataOut),
        .log10Mse   (log10Mse),
        .log10Valid (log10Valid),
        .cfgOut     (cfgOut)
    );

    always #5 busClk = ~busClk;

    function automatic logic [31:0] randWord();
        rngState = lcgNext(rngState);
        return rngState;
    endfunction

    function automatic dqmBusReq makeReq(input logic [12:0] addr, input logic [31:0] data,
                                         input logic cs, input logic [3:0] mask);
        return {addr, data, cs, mask};
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errorCount++;
        $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    // step the model on the edge, check the result pulse, then drive the next inputs.
    task automatic cycle(input dqmBusReq req);
        logic [31:0] w[4];
        @(posedge busClk);
        st = stepModel(st, reset, busReq, samples);
        cycleNo++;
        #1;
        assert (log10Valid === st.outValid)
            else reportMismatch("log10Valid", 32'(log10Valid), 32'(st.outValid));
        if (st.outValid) begin
            assert (log10Mse === st.outValue)
                else reportMismatch("log10Mse", 32'(log10Mse), 32'(st.outValue));
        end
        if (log10Valid) pulseCycles.push_back(cycleNo);
        for (int i = 0; i < 4; i++) w[i] = randWord();
        busReq = req;
        samples = {w[3][31:16], w[2][31:16], w[1][31:16], w[0][31:16]};
    endtask

    task automatic busWrite(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
        cycle(makeReq(addr, data, 1'b1, mask));
        cycle('0);
    endtask

    task automatic busRead(input logic [12:0] addr, input logic cs);
        logic [31:0] exp;
        cycle(makeReq(addr, 32'd0, cs, 4'd0));
        #3;
        exp = expectedRead(st, addr, cs);
        assert (dataOut === exp) else reportMismatch("dataOut", dataOut, exp);
    endtask

    task automatic waitPulses(input int count);
        pulseCycles.delete();
        while (pulseCycles.size() < count) cycle('0);
    endtask

    // the first gaps after a change may still hold old strobes.
    task automatic checkSpacing(input int expected);
        int gap;
        for (int i = 3; i < pulseCycles.size(); i++) begin
            gap = pulseCycles[i] - pulseCycles[i-1];
            assert (gap == expected) else reportMismatch("log10Valid spacing", gap, expected);
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (3) cycle('0);
        reset = 1'b0;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errorCount > testErrors) begin
            testsFailed++;
            $display("test %s: %0d errors", name, errorCount - testErrors);
        end else begin
            $display("test %s: ok", name);
        end
        testErrors = errorCount;
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] pick;
        logic [12:0] addrList[6];
        busClk = 1'b0;
        reset = 1'b1;
        busReq = '0;
        samples = '0;
        rngState = 32'h0650_bd1e;
        st = '0;
        cycleNo = 0;
        errorCount = 0;
        testErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        addrList = '{regMseControl, regLog10Mse, regClksPerBit, regPayloadSize, regSrcSelect,
                     13'h014};
        applyReset();

        for (int i = 0; i < 5; i++) begin
            busRead(addrList[i], 1'b1);
            data = (i == 2 || i == 3) ? 32'(clksPerBitDefault) : 32'd0;
            assert (dataOut === data) else reportMismatch("dataOut", dataOut, data);
        end
        endTest("reset values");

        for (int i = 0; i < 40; i++) begin
            pick = randWord();
            data = randWord();
            busWrite(addrList[pick[31:29] % 6], data, pick[27:24]);
            busRead(addrList[pick[31:29] % 6], 1'b1);
            busRead(addrList[pick[20:18] % 6], pick[16]);
        end
        cycle(makeReq(regMseControl, 32'hFFFF_FFFF, 1'b0, 4'hF));
        cycle('0);
        busRead(regMseControl, 1'b1);
        busRead(13'h1FFC, 1'b1);
        endTest("byte lanes");
        applyReset();

        for (int i = 0; i < 4; i++) begin
            busWrite(regClksPerBit, 32'(cpbList[i]), 4'b0011);
            data = randWord();
            busWrite(regMseControl, {16'(lenList[i]), data[15:0]}, 4'b1111);
            waitPulses(5);
            checkSpacing(cpbList[i] * lenList[i]);
        end
        endTest("pulse spacing");

        busWrite(regClksPerBit, 32'd2, 4'b0011);
        for (int sel = 0; sel < 4; sel++) begin
            data = randWord();
            busWrite(regMseControl, {16'd4, 1'b0, data[14:0]}, 4'b1111);
            busWrite(regSrcSelect, 32'(sel), 4'b0001);
            waitPulses(3);
        end
        endTest("channel select");

        // a full window of large errors overflows the sum.
        busWrite(regMseControl, {16'd16, 16'hFFFF}, 4'b1111);
        busWrite(regClksPerBit, 32'd1, 4'b0011);
        waitPulses(3);
        assert (log10Mse === log10Of(32'hFFFF_FFFF))
            else reportMismatch("log10Mse", 32'(log10Mse), 32'(log10Of(32'hFFFF_FFFF)));
        busWrite(regMseControl, 32'd0, 4'b1100);
        busWrite(regClksPerBit, 32'd3, 4'b0011);
        waitPulses(5);
        checkSpacing(3);
        endTest("saturation and zero window");

        data = randWord();
        busWrite(regLog10Mse, data, 4'b1100);
        pick = randWord();
        busWrite(regPayloadSize, pick, 4'b1100);
        waitPulses(1);
        busRead(regLog10Mse, 1'b1);
        assert (dataOut[31:16] === data[31:16])
            else reportMismatch("dataOut[31:16]", dataOut[31:16], data[31:16]);
        assert (dataOut[15:0] === st.lastLog)
            else reportMismatch("dataOut[15:0]", dataOut[15:0], st.lastLog);
        assert (cfgOut.payloadSize === pick[29:16])
            else reportMismatch("cfgOut.payloadSize", cfgOut.payloadSize, pick[29:16]);
        assert (cfgOut.log10MseOffset === data[31:16])
            else reportMismatch("cfgOut.log10MseOffset", cfgOut.log10MseOffset, data[31:16]);
        endTest("offset and framer outputs");

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // budget in cycles is clksPerBit x length x windows per test plus a margin.
    initial begin : watchdog
        int budget;
        budget = 4 * 2 * 4 * 4 + 1 * 16 * 4 + 3 * 1 * 6 + 3 * 1 * 2 + 1500;
        for (int i = 0; i < 4; i++) begin
            budget += cpbList[i] * lenList[i] * 6;
        end
        #(budget * 10);
        $display("timeout, no result after %0d cycles", budget);
        $display("sim failed");
        $finish;
    end

endmodule

// File: bench/dqmModel.sv
package dqmModel;

    import dqmPkg::*;

    // register shadow, strobe counter, open window and the two result stages.
    typedef struct packed {
        logic [15:0] mseMean;
        logic [15:0] avgLength;
        logic [15:0] clksPerBit;
        logic [13:0] payloadSize;
        logic [3:0]  srcSelect;
        logic [15:0] offset;
        logic [15:0] count;
        logic        termPending;
        logic [15:0] heldSample;
        logic [31:0] sum;
        logic [15:0] bitCount;
        logic        closeValid;
        logic [15:0] closeValue;
        logic        midValid;
        logic [15:0] midValue;
        logic        outValid;
        logic [15:0] outValue;
        logic [15:0] lastLog;
    } modelState;

    function automatic logic [31:0] lcgNext(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // byte n of data replaces byte n of word where mask[n] is set.
    function automatic logic [31:0] mergeLanes(input logic [31:0] word, input logic [31:0] data,
                                               input logic [3:0] mask);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) word[i*8 +: 8] = data[i*8 +: 8];
        end
        return word;
    endfunction

    // p is the leading one, m the 8 bits below it, log2 is p.m in Q8.8.
    function automatic logic [15:0] log10Of(input logic [31:0] v);
        int p;
        int m;
        p = 0;
        for (int i = 0; i < 32; i++) begin
            if (v[i]) p = i;
        end
        m = (p >= 8) ? int'(v >> (p - 8)) & 255 : int'(v << (8 - p)) & 255;
        return 16'(((p * 256 + m) * log10Scale) >> 8);
    endfunction

    // one rising edge, every decision made on the state before the edge.
    function automatic modelState stepModel(input modelState s, input logic rst,
                                            input dqmBusReq req, input sampleBus smp);
        modelState   n;
        logic [31:0] word;
        logic [15:0] lastCount;
        int          mag;
        longint      err;
        longint      total;
        n = s;
        if (rst) begin
            n = '0;
            n.clksPerBit = clksPerBitDefault;
            return n;
        end
        if (req.cs) begin
            case (req.addr)
                regMseControl: begin
                    word = mergeLanes({s.avgLength, s.mseMean}, req.dataIn, req.byteWr);
                    {n.avgLength, n.mseMean} = word;
                end
                regLog10Mse: begin
                    word = mergeLanes({s.offset, 16'd0}, req.dataIn, req.byteWr & 4'b1100);
                    n.offset = word[31:16];
                end
                regClksPerBit: begin
                    word = mergeLanes({16'd0, s.clksPerBit}, req.dataIn, req.byteWr & 4'b0011);
                    n.clksPerBit = word[15:0];
                end
                regPayloadSize: begin
                    word = mergeLanes({2'b00, s.payloadSize, 16'd0}, req.dataIn,
                                      req.byteWr & 4'b1100);
                    n.payloadSize = word[29:16];
                end
                regSrcSelect: if (req.byteWr[0]) n.srcSelect = req.dataIn[3:0];
                default: ;
            endcase
        end
        lastCount = (s.clksPerBit == 16'd0) ? 16'd0 : s.clksPerBit - 16'd1;
        n.termPending = (s.count >= lastCount);
        n.count = n.termPending ? 16'd0 : s.count + 16'd1;
        if (n.termPending) n.heldSample = smp[s.srcSelect[1:0]];
        if (s.outValid) n.lastLog = s.outValue;
        n.outValid = s.midValid;
        n.outValue = s.midValue;
        n.midValid = s.closeValid;
        n.midValue = s.closeValue;
        n.closeValid = 1'b0;
        if (s.termPending) begin
            mag = int'($signed(s.heldSample));
            mag = (mag < 0) ? -mag : mag;
            err = longint'(mag) - longint'(s.mseMean);
            total = longint'(s.sum) + err * err;
            if (total > 64'hFFFF_FFFF) total = 64'hFFFF_FFFF;
            // a length of zero closes the window after every term.
            if (int'(s.bitCount) + 1 >= ((s.avgLength == 16'd0) ? 1 : int'(s.avgLength))) begin
                n.closeValid = 1'b1;
                n.closeValue = log10Of(32'(total));
                n.sum = '0;
                n.bitCount = '0;
            end else begin
                n.sum = 32'(total);
                n.bitCount = s.bitCount + 16'd1;
            end
        end
        return n;
    endfunction

    function automatic logic [31:0] expectedRead(input modelState s, input logic [12:0] addr,
                                                 input logic cs);
        if (!cs) return '0;
        case (addr)
            regMseControl:  return {s.avgLength, s.mseMean};
            regLog10Mse:    return {s.offset, s.lastLog};
            regClksPerBit:  return {2'b00, s.payloadSize, s.clksPerBit};
            regPayloadSize: return {2'b00, s.payloadSize, s.clksPerBit};
            regSrcSelect:   return {28'd0, s.srcSelect};
            default:        return '0;
        endcase
    endfunction

endpackage

// File: design/dqmTop.sv
module dqmTop (
    input  logic               busClk,
    input  logic               reset,
    input  dqmPkg::dqmBusReq   busReq,
    input  dqmPkg::sampleBus   samples,
    output logic [31:0]        dataOut,
    output logic signed [15:0] log10Mse,
    output logic               log10Valid,
    output dqmPkg::dqmConfig   cfgOut
);

    import dqmPkg::*;

    dqmConfig            cfg;
    logic                bitStrobe;
    logic [sumWidth-1:0] mseSum;
    logic                mseValid;

    dqmRegs regs (
        .busClk     (busClk),
        .reset      (reset),
        .busReq     (busReq),
        .log10Mse   (log10Mse),
        .log10Valid (log10Valid),
        .dataOut    (dataOut),
        .cfg        (cfg)
    );

    bitStrobeGen strobeGen (
        .busClk     (busClk),
        .reset      (reset),
        .clksPerBit (cfg.clksPerBit),
        .bitStrobe  (bitStrobe)
    );

    mseAccumulator accumulator (
        .busClk    (busClk),
        .reset     (reset),
        .samples   (samples),
        .cfg       (cfg),
        .bitStrobe (bitStrobe),
        .mseSum    (mseSum),
        .mseValid  (mseValid)
    );

    log10Approx log10Conv (
        .busClk     (busClk),
        .reset      (reset),
        .mseSum     (mseSum),
        .mseValid   (mseValid),
        .log10Mse   (log10Mse),
        .log10Valid (log10Valid)
    );

    // framer takes payloadSize and the offset from here.
    assign cfgOut = cfg;

endmodule

// File: design/log10Approx.sv
module log10Approx (
    input  logic                        busClk,
    input  logic                        reset,
    input  logic [dqmPkg::sumWidth-1:0] mseSum,
    input  logic                        mseValid,
    output logic signed [15:0]          log10Mse,
    output logic                        log10Valid
);

    import dqmPkg::*;

    logic [4:0]          leadPos;
    logic [sumWidth-1:0] normalized;
    logic [7:0]          mantissa;
    logic [12:0]         log2Reg;
    logic                stage1Valid;
    logic [19:0]         scaled;

    // position of the highest set bit, zero for an input of zero.
    function automatic logic [4:0] leadingOne(input logic [sumWidth-1:0] value);
        logic [4:0] pos;
        pos = '0;
        for (int i = 0; i < sumWidth; i++) begin
            if (value[i]) begin
                pos = 5'(i);
            end
        end
        return pos;
    endfunction

    always_comb begin
        leadPos = leadingOne(mseSum);
        // shift the leading one up to the msb, the 8 bits below it are the mantissa.
        normalized = mseSum << (5'(sumWidth - 1) - leadPos);
        mantissa = normalized[sumWidth-2 -: 8];
    end

    // stage one, log2 in Q8.8.
    always_ff @(posedge busClk) begin
        if (mseValid) begin
            log2Reg <= {leadPos, mantissa};
        end
    end

    assign scaled = 20'(log2Reg) * 20'(log10Scale);

    // stage two, log10 = log2 x log10(2).
    always_ff @(posedge busClk) begin
        if (stage1Valid) begin
            log10Mse <= {4'd0, scaled[19:8]};
        end
    end

    always_ff @(posedge busClk) begin
        if (reset) begin
            stage1Valid <= 1'b0;
            log10Valid  <= 1'b0;
        end else begin
            stage1Valid <= mseValid;
            log10Valid  <= stage1Valid;
        end
    end

endmodule

// File: design/mseAccumulator.sv
module mseAccumulator (
    input  logic                        busClk,
    input  logic                        reset,
    input  dqmPkg::sampleBus            samples,
    input  dqmPkg::dqmConfig            cfg,
    input  logic                        bitStrobe,
    output logic [dqmPkg::sumWidth-1:0] mseSum,
    output logic                        mseValid
);

    import dqmPkg::*;

    logic [sampleWidth-1:0] sampleReg;
    logic                   termValid;
    logic [sampleWidth-1:0] magnitude;
    logic [sampleWidth-1:0] absError;
    logic [sumWidth-1:0]    sqError;
    logic [sumWidth:0]      rawSum;
    logic [sumWidth-1:0]    nextSum;
    logic [sumWidth-1:0]    sum;
    logic [15:0]            bitCount;
    logic [15:0]            lastBit;
    logic                   windowDone;

    // capture the selected channel at the bit boundary.
    always_ff @(posedge busClk) begin
        if (bitStrobe) begin
            sampleReg <= samples[cfg.sourceSelect];
        end
    end

    always_ff @(posedge busClk) begin
        if (reset) begin
            termValid <= 1'b0;
        end else begin
            termValid <= bitStrobe;
        end
    end

    always_comb begin
        // magnitude of -32768 is 32768, still fits unsigned 16 bits.
        if (sampleReg[sampleWidth-1]) begin
            magnitude = ~sampleReg + 1'b1;
        end else begin
            magnitude = sampleReg;
        end
        if (magnitude >= cfg.mseMean) begin
            absError = magnitude - cfg.mseMean;
        end else begin
            absError = cfg.mseMean - magnitude;
        end
        sqError = absError * absError;
        rawSum = sum + sqError;
        // clamp at all ones on carry out.
        nextSum = rawSum[sumWidth] ? '1 : rawSum[sumWidth-1:0];
        lastBit = (cfg.mseAvgLength == 16'd0) ? 16'd0 : cfg.mseAvgLength - 16'd1;
        windowDone = (bitCount >= lastBit);
    end

    always_ff @(posedge busClk) begin
        if (reset) begin
            sum      <= '0;
            bitCount <= '0;
            mseValid <= 1'b0;
        end else begin
            mseValid <= 1'b0;
            if (termValid) begin
                if (windowDone) begin
                    sum      <= '0;
                    bitCount <= '0;
                    mseValid <= 1'b1;
                end else begin
                    sum      <= nextSum;
                    bitCount <= bitCount + 16'd1;
                end
            end
        end
    end

    // finished window total, held until the next window closes.
    always_ff @(posedge busClk) begin
        if (termValid && windowDone) begin
            mseSum <= nextSum;
        end
    end

endmodule

// File: design/bitStrobeGen.sv
module bitStrobeGen (
    input  logic        busClk,
    input  logic        reset,
    input  logic [15:0] clksPerBit,
    output logic        bitStrobe
);

    logic [15:0] count;
    logic [15:0] lastCount;

    // a setting of zero behaves like one.
    always_comb begin
        if (clksPerBit == 16'd0) begin
            lastCount = '0;
        end else begin
            lastCount = clksPerBit - 16'd1;
        end
    end

    // greater-or-equal so a smaller setting never lets the count run away.
    assign bitStrobe = (count >= lastCount);

    always_ff @(posedge busClk) begin
        if (reset) begin
            count <= '0;
        end else if (bitStrobe) begin
            count <= '0;
        end else begin
            count <= count + 16'd1;
        end
    end

endmodule

// File: design/dqmRegs.sv
module dqmRegs (
    input  logic                busClk,
    input  logic                reset,
    input  dqmPkg::dqmBusReq    busReq,
    input  logic signed [15:0]  log10Mse,
    input  logic                log10Valid,
    output logic [31:0]         dataOut,
    output dqmPkg::dqmConfig    cfg
);

    import dqmPkg::*;

    logic [15:0]        mseMean;
    logic [15:0]        mseAvgLength;
    logic [15:0]        clksPerBit;
    logic [13:0]        payloadSize;
    logic [3:0]         srcSelect;
    logic signed [15:0] log10MseOffset;
    logic signed [15:0] lastLog10;

    // byte lane writes, each lane only touches fields mapped to it.
    always_ff @(posedge busClk) begin
        if (reset) begin
            mseMean        <= '0;
            mseAvgLength   <= '0;
            clksPerBit     <= clksPerBitDefault;
            payloadSize    <= '0;
            srcSelect      <= '0;
            log10MseOffset <= '0;
        end else if (busReq.cs) begin
            if (busReq.byteWr[0]) begin
                case (busReq.addr)
                    regMseControl: mseMean[7:0] <= busReq.dataIn[7:0];
                    regClksPerBit: clksPerBit[7:0] <= busReq.dataIn[7:0];
                    regSrcSelect:  srcSelect <= busReq.dataIn[3:0];
                    default: ;
                endcase
            end
            if (busReq.byteWr[1]) begin
                case (busReq.addr)
                    regMseControl: mseMean[15:8] <= busReq.dataIn[15:8];
                    regClksPerBit: clksPerBit[15:8] <= busReq.dataIn[15:8];
                    default: ;
                endcase
            end
            if (busReq.byteWr[2]) begin
                case (busReq.addr)
                    regLog10Mse:    log10MseOffset[7:0] <= busReq.dataIn[23:16];
                    regMseControl:  mseAvgLength[7:0] <= busReq.dataIn[23:16];
                    regPayloadSize: payloadSize[7:0] <= busReq.dataIn[23:16];
                    default: ;
                endcase
            end
            if (busReq.byteWr[3]) begin
                case (busReq.addr)
                    regLog10Mse:    log10MseOffset[15:8] <= busReq.dataIn[31:24];
                    regMseControl:  mseAvgLength[15:8] <= busReq.dataIn[31:24];
                    // payload size is only 14 bits wide.
                    regPayloadSize: payloadSize[13:8] <= busReq.dataIn[29:24];
                    default: ;
                endcase
            end
        end
    end

    // last result from the log10 pipeline.
    always_ff @(posedge busClk) begin
        if (reset) begin
            lastLog10 <= '0;
        end else if (log10Valid) begin
            lastLog10 <= log10Mse;
        end
    end

    always_comb begin
        cfg.mseMean        = mseMean;
        cfg.mseAvgLength   = mseAvgLength;
        cfg.clksPerBit     = clksPerBit;
        cfg.payloadSize    = payloadSize;
        cfg.sourceSelect   = srcSelect[1:0];
        cfg.log10MseOffset = log10MseOffset;
    end

    // readback, clksPerBit and payloadSize share one word at both addresses.
    always_comb begin
        dataOut = '0;
        if (busReq.cs) begin
            case (busReq.addr)
                regMseControl:  dataOut = {mseAvgLength, mseMean};
                regLog10Mse:    dataOut = {log10MseOffset, lastLog10};
                regClksPerBit:  dataOut = {2'b00, payloadSize, clksPerBit};
                regPayloadSize: dataOut = {2'b00, payloadSize, clksPerBit};
                regSrcSelect:   dataOut = {28'd0, srcSelect};
                default:        dataOut = '0;
            endcase
        end
    end

endmodule

// File: design/dqmPkg.sv
package dqmPkg;

    // datapath widths.
    localparam int sampleWidth = 16;
    localparam int sumWidth = 32;
    localparam int numChannels = 4;

    // clksPerBit value after reset.
    localparam logic [15:0] clksPerBitDefault = 16'd8;

    // log10(2) in Q0.8, 0.30103 x 256.
    localparam int log10Scale = 77;

    // register map, byte addresses.
    typedef enum logic [12:0] {
        regMseControl  = 13'h000,
        regLog10Mse    = 13'h004,
        regClksPerBit  = 13'h008,
        regPayloadSize = 13'h00C,
        regSrcSelect   = 13'h010
    } regAddr;

    // bus request, one write strobe per byte lane.
    typedef struct packed {
        logic [12:0] addr;
        logic [31:0] dataIn;
        logic        cs;
        logic [3:0]  byteWr;
    } dqmBusReq;

    // configuration seen by the datapath and the framer.
    typedef struct packed {
        logic [15:0]        mseMean;
        logic [15:0]        mseAvgLength;
        logic [15:0]        clksPerBit;
        logic [13:0]        payloadSize;
        logic [1:0]         sourceSelect;
        logic signed [15:0] log10MseOffset;
    } dqmConfig;

    // four soft-decision channels, each a signed two's complement sample.
    typedef logic [numChannels-1:0][sampleWidth-1:0] sampleBus;

endpackage
